// File: source/conv_pkg.sv
package conv_pkg;

    // One half-precision word, seen as raw bits or as its fields
    typedef union packed {
        logic [15:0] bits;
        struct packed {
            logic       sign;
            logic [4:0] exp;
            logic [9:0] man;
        } f;
    } fp16_t;

    localparam logic [4:0]  FP16_EXP_BIAS = 5'd15;

    // All-ones exponent marks infinity
    localparam logic [4:0]  FP16_EXP_MAX  = 5'd31;

    localparam logic [15:0] FP16_ZERO     = 16'h0000;

endpackage

// File: source/fp16_mul.sv
`timescale 1ns/10ps

module fp16_mul (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_nd,
    input  conv_pkg::fp16_t i_a,
    input  conv_pkg::fp16_t i_b,
    output logic            o_rdy,
    output conv_pkg::fp16_t o_result
);

    logic              s1_vld;
    logic              s1_sign;
    logic              s1_zero;
    logic              s1_inf;
    logic signed [6:0] s1_exp;
    logic [21:0]       s1_prod;

    logic signed [6:0] exp_n;
    logic [9:0]        man_n;
    conv_pkg::fp16_t   res_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            o_rdy  <= 1'b0;
        end else begin
            s1_vld <= i_nd;
            o_rdy  <= s1_vld;
        end
    end

    // Subnormal operands count as zero
    always_ff @(posedge clk) begin
        if (i_nd) begin
            s1_sign <= i_a.f.sign ^ i_b.f.sign;
            s1_zero <= (i_a.f.exp == 5'd0) || (i_b.f.exp == 5'd0);
            s1_inf  <= (i_a.f.exp == conv_pkg::FP16_EXP_MAX) ||
                       (i_b.f.exp == conv_pkg::FP16_EXP_MAX);
            s1_exp  <= 7'(i_a.f.exp) + 7'(i_b.f.exp) - 7'(conv_pkg::FP16_EXP_BIAS);
            s1_prod <= {1'b1, i_a.f.man} * {1'b1, i_b.f.man};
        end
    end

    // Product of two 1.x significands is below 4, so one bit of normalization
    always_comb begin
        if (s1_prod[21]) begin
            exp_n = s1_exp + 7'sd1;
            man_n = s1_prod[20:11];
        end else begin
            exp_n = s1_exp;
            man_n = s1_prod[19:10];
        end
        res_n.bits = conv_pkg::FP16_ZERO;
        if (!s1_zero) begin
            if (s1_inf || exp_n >= $signed(7'(conv_pkg::FP16_EXP_MAX))) begin
                res_n.f.sign = s1_sign;
                res_n.f.exp  = conv_pkg::FP16_EXP_MAX;
                res_n.f.man  = 10'd0;
            end else if (exp_n > 7'sd0) begin
                res_n.f.sign = s1_sign;
                res_n.f.exp  = exp_n[4:0];
                res_n.f.man  = man_n;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            o_result <= res_n;
        end
    end

endmodule

// File: source/fp16_add.sv
`timescale 1ns/10ps

module fp16_add (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_nd,
    input  conv_pkg::fp16_t i_a,
    input  conv_pkg::fp16_t i_b,
    output logic            o_rdy,
    output conv_pkg::fp16_t o_result
);

    conv_pkg::fp16_t   a_f;
    conv_pkg::fp16_t   b_f;
    conv_pkg::fp16_t   big;
    conv_pkg::fp16_t   small_op;
    logic [4:0]        exp_diff;
    logic [14:0]       big_ext;
    logic [14:0]       small_ext;
    logic [14:0]       sum_c;

    logic              s1_vld;
    logic              s1_sign;
    logic              s1_inf;
    logic [4:0]        s1_exp;
    logic [14:0]       s1_sum;

    logic [3:0]        lz;
    logic [13:0]       norm;
    logic signed [6:0] exp_n;
    logic [9:0]        man_n;
    conv_pkg::fp16_t   res_n;

    // Align the smaller operand, three guard bits below the LSB
    always_comb begin
        a_f = i_a;
        b_f = i_b;
        if (i_a.f.exp == 5'd0) begin
            a_f.f.man = 10'd0;
        end
        if (i_b.f.exp == 5'd0) begin
            b_f.f.man = 10'd0;
        end
        if ({a_f.f.exp, a_f.f.man} >= {b_f.f.exp, b_f.f.man}) begin
            big      = a_f;
            small_op = b_f;
        end else begin
            big      = b_f;
            small_op = a_f;
        end
        exp_diff  = big.f.exp - small_op.f.exp;
        big_ext   = {1'b0, big.f.exp != 5'd0, big.f.man, 3'b000};
        small_ext = {1'b0, small_op.f.exp != 5'd0, small_op.f.man, 3'b000} >> exp_diff;
        if (big.f.sign == small_op.f.sign) begin
            sum_c = big_ext + small_ext;
        end else begin
            sum_c = big_ext - small_ext;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            o_rdy  <= 1'b0;
        end else begin
            s1_vld <= i_nd;
            o_rdy  <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (i_nd) begin
            s1_sign <= big.f.sign;
            s1_inf  <= big.f.exp == conv_pkg::FP16_EXP_MAX;
            s1_exp  <= big.f.exp;
            s1_sum  <= sum_c;
        end
    end

    // Leading one search, highest set bit wins
    always_comb begin
        lz = 4'd0;
        for (int i = 0; i < 14; i++) begin
            if (s1_sum[i]) begin
                lz = 4'(13 - i);
            end
        end
        norm = s1_sum[13:0] << lz;
        if (s1_sum[14]) begin
            exp_n = 7'(s1_exp) + 7'd1;
            man_n = s1_sum[13:4];
        end else begin
            exp_n = 7'(s1_exp) - 7'(lz);
            man_n = norm[12:3];
        end
        res_n.bits = conv_pkg::FP16_ZERO;
        if (s1_inf || (s1_sum != 15'd0 &&
                       exp_n >= $signed(7'(conv_pkg::FP16_EXP_MAX)))) begin
            res_n.f.sign = s1_sign;
            res_n.f.exp  = conv_pkg::FP16_EXP_MAX;
            res_n.f.man  = 10'd0;
        end else if (s1_sum != 15'd0 && exp_n > 7'sd0) begin
            res_n.f.sign = s1_sign;
            res_n.f.exp  = exp_n[4:0];
            res_n.f.man  = man_n;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            o_result <= res_n;
        end
    end

endmodule

// File: source/conv_3x3.sv
`timescale 1ns/10ps

module conv_3x3 #(
    parameter bit P_RELU = 1'b1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_start,
    input  logic [143:0]    i_pixels,
    input  logic [143:0]    i_weights,
    input  conv_pkg::fp16_t i_bias,
    output conv_pkg::fp16_t o_result,
    output logic            o_valid
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_MULT = 3'd1;
    localparam logic [2:0] ST_SUM1 = 3'd2;
    localparam logic [2:0] ST_SUM2 = 3'd3;
    localparam logic [2:0] ST_SUM3 = 3'd4;
    localparam logic [2:0] ST_SUM4 = 3'd5;

    logic [2:0]      state;
    logic            stage_done;
    logic [143:0]    pix_q;
    logic [143:0]    wgt_q;
    conv_pkg::fp16_t bias_q;

    logic            mul_nd;
    logic [8:0]      mul_rdy;
    conv_pkg::fp16_t prod [9];

    logic [3:0]      add_nd;
    logic [3:0]      add_rdy;
    conv_pkg::fp16_t add_a [4];
    conv_pkg::fp16_t add_b [4];
    conv_pkg::fp16_t psum [4];

    for (genvar g = 0; g < 9; g++) begin : g_mul
        fp16_mul u_mul (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_nd     (mul_nd),
            .i_a      (pix_q[16*g +: 16]),
            .i_b      (wgt_q[16*g +: 16]),
            .o_rdy    (mul_rdy[g]),
            .o_result (prod[g])
        );
    end

    for (genvar g = 0; g < 4; g++) begin : g_add
        fp16_add u_add (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_nd     (add_nd[g]),
            .i_a      (add_a[g]),
            .i_b      (add_b[g]),
            .o_rdy    (add_rdy[g]),
            .o_result (psum[g])
        );
    end

    // Ready condition of the stage in flight
    always_comb begin
        case (state)
            ST_MULT: stage_done = &mul_rdy;
            ST_SUM1: stage_done = &add_rdy;
            ST_SUM2: stage_done = add_rdy[0] & add_rdy[1] & add_rdy[3];
            ST_SUM3: stage_done = add_rdy[0];
            ST_SUM4: stage_done = add_rdy[0];
            default: stage_done = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mul_nd  <= 1'b0;
            add_nd  <= 4'b0000;
            o_valid <= 1'b0;
        end else begin
            mul_nd  <= 1'b0;
            add_nd  <= 4'b0000;
            o_valid <= 1'b0;
            case (state)
                ST_IDLE: if (i_start) begin
                    state  <= ST_MULT;
                    mul_nd <= 1'b1;
                end
                ST_MULT: if (stage_done) begin
                    state  <= ST_SUM1;
                    add_nd <= 4'b1111;
                end
                // Side pair of last product and bias runs on adder 3
                ST_SUM1: if (stage_done) begin
                    state  <= ST_SUM2;
                    add_nd <= 4'b1011;
                end
                ST_SUM2: if (stage_done) begin
                    state  <= ST_SUM3;
                    add_nd <= 4'b0001;
                end
                ST_SUM3: if (stage_done) begin
                    state  <= ST_SUM4;
                    add_nd <= 4'b0001;
                end
                ST_SUM4: if (stage_done) begin
                    state   <= ST_IDLE;
                    o_valid <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Operand steering for the adder tree
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: if (i_start) begin
                pix_q  <= i_pixels;
                wgt_q  <= i_weights;
                bias_q <= i_bias;
            end
            ST_MULT: if (stage_done) begin
                for (int k = 0; k < 4; k++) begin
                    add_a[k] <= prod[2*k];
                    add_b[k] <= prod[2*k+1];
                end
            end
            ST_SUM1: if (stage_done) begin
                add_a[0] <= psum[0];
                add_b[0] <= psum[1];
                add_a[1] <= psum[2];
                add_b[1] <= psum[3];
                add_a[3] <= prod[8];
                add_b[3] <= bias_q;
            end
            ST_SUM2: if (stage_done) begin
                add_a[0] <= psum[0];
                add_b[0] <= psum[1];
            end
            ST_SUM3: if (stage_done) begin
                add_a[0] <= psum[0];
                add_b[0] <= psum[3];
            end
            ST_SUM4: if (stage_done) begin
                o_result <= (P_RELU && psum[0].f.sign) ? conv_pkg::FP16_ZERO : psum[0];
            end
            default: ;
        endcase
    end

endmodule

// File: source/conv_1x1.sv
`timescale 1ns/10ps

module conv_1x1 #(
    parameter bit P_RELU = 1'b1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_start,
    input  conv_pkg::fp16_t i_pixel,
    input  conv_pkg::fp16_t i_weight,
    input  conv_pkg::fp16_t i_bias,
    output conv_pkg::fp16_t o_result,
    output logic            o_valid
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_MULT  = 2'd1;
    localparam logic [1:0] ST_ACCUM = 2'd2;

    logic [1:0]      state;
    conv_pkg::fp16_t pix_q;
    conv_pkg::fp16_t wgt_q;
    conv_pkg::fp16_t bias_q;

    logic            mul_nd;
    logic            mul_rdy;
    conv_pkg::fp16_t prod;
    logic            add_nd;
    logic            add_rdy;
    conv_pkg::fp16_t add_a;
    conv_pkg::fp16_t add_b;
    conv_pkg::fp16_t sum;

    fp16_mul u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_nd     (mul_nd),
        .i_a      (pix_q),
        .i_b      (wgt_q),
        .o_rdy    (mul_rdy),
        .o_result (prod)
    );

    fp16_add u_add (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_nd     (add_nd),
        .i_a      (add_a),
        .i_b      (add_b),
        .o_rdy    (add_rdy),
        .o_result (sum)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mul_nd  <= 1'b0;
            add_nd  <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            mul_nd  <= 1'b0;
            add_nd  <= 1'b0;
            o_valid <= 1'b0;
            case (state)
                ST_IDLE: if (i_start) begin
                    state  <= ST_MULT;
                    mul_nd <= 1'b1;
                end
                ST_MULT: if (mul_rdy) begin
                    state  <= ST_ACCUM;
                    add_nd <= 1'b1;
                end
                ST_ACCUM: if (add_rdy) begin
                    state   <= ST_IDLE;
                    o_valid <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_start) begin
            pix_q  <= i_pixel;
            wgt_q  <= i_weight;
            bias_q <= i_bias;
        end
        if (state == ST_MULT && mul_rdy) begin
            add_a <= prod;
            add_b <= bias_q;
        end
        // Negative sums clamp to zero
        if (state == ST_ACCUM && add_rdy) begin
            o_result <= (P_RELU && sum.f.sign) ? conv_pkg::FP16_ZERO : sum;
        end
    end

endmodule

// File: source/conv_unit.sv
`timescale 1ns/10ps

module conv_unit #(
    parameter bit P_RELU = 1'b1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_start,
    input  logic            i_kernel_sel,
    input  logic [143:0]    i_pixels,
    input  logic [143:0]    i_weights,
    input  conv_pkg::fp16_t i_bias,
    output conv_pkg::fp16_t o_result,
    output logic            o_valid,
    output logic            o_busy
);

    logic            start_ok;
    logic            start_3x3;
    logic            start_1x1;
    conv_pkg::fp16_t res_3x3;
    conv_pkg::fp16_t res_1x1;
    logic            valid_3x3;
    logic            valid_1x1;

    // Starts while busy are dropped
    assign start_ok  = i_start & ~o_busy;
    assign start_3x3 = start_ok & ~i_kernel_sel;
    assign start_1x1 = start_ok & i_kernel_sel;

    conv_3x3 #(
        .P_RELU (P_RELU)
    ) u_conv_3x3 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_start   (start_3x3),
        .i_pixels  (i_pixels),
        .i_weights (i_weights),
        .i_bias    (i_bias),
        .o_result  (res_3x3),
        .o_valid   (valid_3x3)
    );

    conv_1x1 #(
        .P_RELU (P_RELU)
    ) u_conv_1x1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_start  (start_1x1),
        .i_pixel  (i_pixels[15:0]),
        .i_weight (i_weights[15:0]),
        .i_bias   (i_bias),
        .o_result (res_1x1),
        .o_valid  (valid_1x1)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_busy  <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid_3x3 | valid_1x1;
            if (start_ok) begin
                o_busy <= 1'b1;
            end else if (valid_3x3 || valid_1x1) begin
                o_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_1x1) begin
            o_result <= res_1x1;
        end else if (valid_3x3) begin
            o_result <= res_3x3;
        end
    end

endmodule

// File: tests/conv_unit_checker.sv
`timescale 1ns/10ps

module conv_unit_checker (
    input logic clk,
    input logic rst_n,
    input logic i_valid,
    input logic i_busy
);

    int err_count = 0;

    // Result strobe is a single-cycle pulse
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i_valid |=> !i_valid)
    else begin
        $error("o_valid stayed high for two cycles");
        err_count++;
    end

    valid_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_valid |-> $past(i_busy))
    else begin
        $error("o_valid without o_busy in the cycle before");
        err_count++;
    end

    // Busy drops on the valid edge only
    busy_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_busy) |-> i_valid)
    else begin
        $error("o_busy fell without o_valid");
        err_count++;
    end

endmodule

// File: tests/conv_unit_tb.sv
`timescale 1ns/10ps

module conv_unit_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    logic            clk;
    logic            rst_n;
    logic            i_start;
    logic            i_kernel_sel;
    logic [143:0]    i_pixels;
    logic [143:0]    i_weights;
    conv_pkg::fp16_t i_bias;
    conv_pkg::fp16_t o_result;
    logic            o_valid;
    logic            o_busy;

    real pix_r [9];
    real wgt_r [9];
    real bias_r;
    int  cycle_cnt = 0;

    conv_unit #(
        .P_RELU (1'b1)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (i_start),
        .i_kernel_sel (i_kernel_sel),
        .i_pixels     (i_pixels),
        .i_weights    (i_weights),
        .i_bias       (i_bias),
        .o_result     (o_result),
        .o_valid      (o_valid),
        .o_busy       (o_busy)
    );

    bind conv_unit conv_unit_checker u_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (o_valid),
        .i_busy  (o_busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Simulation stopped by timeout");
        end else if (DUT.u_checker.err_count != 0) begin
            $display("A checker assertion on o_valid or o_busy failed");
            $display("TEST FAIL");
            $fatal(1, "Checker reported a failure");
        end
    end

    // Exact values only, so the mantissa never needs rounding
    function automatic logic [15:0] to_fp16(real v);
        logic       sign;
        real        mag;
        int         e;
        logic [9:0] man;
        if (v == 0.0) begin
            return 16'h0000;
        end
        sign = (v < 0.0);
        mag  = sign ? -v : v;
        e    = 0;
        while (mag >= 2.0) begin
            mag = mag / 2.0;
            e++;
        end
        while (mag < 1.0) begin
            mag = mag * 2.0;
            e--;
        end
        man = 10'($rtoi((mag - 1.0) * 1024.0));
        return {sign, 5'(e + 15), man};
    endfunction

    function automatic logic [15:0] expected_result(logic sel);
        real acc;
        acc = bias_r;
        if (sel) begin
            acc = acc + pix_r[0] * wgt_r[0];
        end else begin
            for (int k = 0; k < 9; k++) begin
                acc = acc + pix_r[k] * wgt_r[k];
            end
        end
        if (acc < 0.0) begin
            acc = 0.0;
        end
        return to_fp16(acc);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic set_ramp(real p0, real pstep, real w0, real wstep, real b);
        for (int k = 0; k < 9; k++) begin
            pix_r[k] = p0 + pstep * k;
            wgt_r[k] = w0 + wstep * k;
        end
        bias_r = b;
    endtask

    task automatic start_conv(logic sel);
        @(posedge clk);
        i_kernel_sel <= sel;
        for (int k = 0; k < 9; k++) begin
            i_pixels[16*k +: 16]  <= to_fp16(pix_r[k]);
            i_weights[16*k +: 16] <= to_fp16(wgt_r[k]);
        end
        i_bias  <= to_fp16(bias_r);
        i_start <= 1'b1;
    endtask

    // Cycles counted from the edge that drove the start strobe
    task automatic wait_result(output logic [15:0] res, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(posedge clk);
            i_start <= 1'b0;
            cycles++;
            @(negedge clk);
            seen = o_valid;
        end
        res = o_result;
    endtask

    task automatic run_conv(string name, logic sel);
        logic [15:0] res;
        int          cycles;
        start_conv(sel);
        wait_result(res, cycles);
        check_value(name, expected_result(sel), res);
        check_value({name, " latency"}, sel ? 8 : 17, cycles);
    endtask

    task automatic conv3x3_positive();
        set_ramp(0.5, 0.5, -3.0, 1.0, 2.0);
        run_conv("3x3 positive", 1'b0);
    endtask

    task automatic conv1x1_latency();
        set_ramp(3.5, 0.0, -2.0, 0.0, 10.0);
        run_conv("1x1 product", 1'b1);
    endtask

    task automatic relu_clamp();
        set_ramp(1.0, 1.0, -1.0, 0.0, 4.0);
        run_conv("relu 3x3 negative", 1'b0);
        set_ramp(2.0, 0.0, 3.0, 0.0, -7.0);
        run_conv("relu 1x1 negative", 1'b1);
        set_ramp(1.0, 0.0, 1.0, 0.0, -9.0);
        run_conv("relu 3x3 cancel", 1'b0);
        set_ramp(2.0, 0.0, -1.5, 0.0, 3.0);
        run_conv("relu 1x1 cancel", 1'b1);
    endtask

    task automatic start_while_busy();
        logic [15:0] exp_first;
        logic [15:0] res;
        int          cycles;
        int          extra;
        set_ramp(0.0, 1.0, 1.0, 0.0, 0.5);
        exp_first = expected_result(1'b0);
        start_conv(1'b0);
        repeat (3) begin
            @(posedge clk);
            i_start <= 1'b0;
        end
        @(negedge clk);
        check_value("start busy flag", 1, o_busy);
        // Second operand set must not reach either engine
        set_ramp(2.0, 0.0, 2.0, 0.0, 1.0);
        start_conv(1'b1);
        wait_result(res, cycles);
        check_value("start busy result", exp_first, res);
        extra = 0;
        repeat (25) begin
            @(negedge clk);
            if (o_valid) begin
                extra++;
            end
        end
        check_value("start busy pulses", 0, extra);
    endtask

    task automatic random_sets();
        logic sel;
        for (int i = 0; i < 20; i++) begin
            sel = i[0];
            for (int k = 0; k < 9; k++) begin
                pix_r[k] = real'(int'($urandom_range(6)) - 3);
                wgt_r[k] = real'(int'($urandom_range(6)) - 3);
            end
            bias_r = real'(int'($urandom_range(16)) - 8);
            run_conv($sformatf("random run %0d", i), sel);
        end
    endtask

    initial begin
        void'($urandom(32'h7e6b5855));
        rst_n        = 1'b0;
        i_start      = 1'b0;
        i_kernel_sel = 1'b0;
        i_pixels     = '0;
        i_weights    = '0;
        i_bias       = conv_pkg::FP16_ZERO;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        conv3x3_positive();
        conv1x1_latency();
        relu_clamp();
        start_while_busy();
        random_sets();

        repeat (4) @(posedge clk);
        if (DUT.u_checker.err_count != 0) begin
            $display("Assertion failures seen: %0d", DUT.u_checker.err_count);
            $display("TEST FAIL");
            $fatal(1, "Checker reported failures");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: verilog.f
source/conv_pkg.sv
source/fp16_mul.sv
source/fp16_add.sv
source/conv_3x3.sv
source/conv_1x1.sv
source/conv_unit.sv
tests/conv_unit_checker.sv
tests/conv_unit_tb.sv
